// File: code_lock.f
rtl/keypad_defs_pkg.sv
rtl/lock_defs_pkg.sv
rtl/key_decoder.sv
rtl/code_lock_ctrl.sv
rtl/lockout_timer.sv
rtl/buzzer_pattern.sv
rtl/code_lock_top.sv
tests/code_lock_checker.sv
tests/code_lock_tb.sv

// File: Bender.yml
package:
  name: code_lock

sources:
  - rtl/keypad_defs_pkg.sv
  - rtl/lock_defs_pkg.sv
  - rtl/key_decoder.sv
  - rtl/code_lock_ctrl.sv
  - rtl/lockout_timer.sv
  - rtl/buzzer_pattern.sv
  - rtl/code_lock_top.sv
  - target: test
    files:
      - tests/code_lock_checker.sv
      - tests/code_lock_tb.sv

// File: tests/code_lock_tb.sv
`timescale 1ns/10ps

module code_lock_tb;
    import keypad_defs_pkg::*;
    import lock_defs_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int TICK            = 20;
    localparam int TONE            = 2;
    localparam int NUM_PRESSES     = 50;
    localparam int LOCKOUT_LIMIT   = 21 * TICK + 20;  // cycles for locked_out to fall
    localparam int WATCHDOG_CYCLES = NUM_PRESSES * 4 + 2 * LOCKOUT_LIMIT + 200;

    logic     clk = 1'b0;
    logic     reset;
    keypad_t  keys;
    display_t display;
    count_t   entered;
    tries_t   tries;
    logic     locked_out;
    logic     buzzer;
    integer   seed = 32'h40bc;

    code_lock_top #(
        .TICK_CYCLES (TICK),
        .TONE_UNIT   (TONE)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .keys       (keys),
        .display    (display),
        .entered    (entered),
        .tries      (tries),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    code_lock_checker #(
        .TICK_CYCLES (TICK)
    ) chk (
        .clk        (clk),
        .reset      (reset),
        .keys       (keys),
        .display    (display),
        .entered    (entered),
        .tries      (tries),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic keypad_t digit_key(input int d);
        case (d)
            0:       return KEY_0;
            1:       return KEY_1;
            2:       return KEY_2;
            3:       return KEY_3;
            4:       return KEY_4;
            5:       return KEY_5;
            6:       return KEY_6;
            7:       return KEY_7;
            8:       return KEY_8;
            9:       return KEY_9;
            default: return '0;
        endcase
    endfunction

    function automatic int random_digit();
        return {$random(seed)} % 10;
    endfunction

    // called 5 ns after an edge, returns 5 ns after an edge
    task automatic press(input keypad_t k);
        keys = k;
        repeat (2) @(posedge clk);
        #5;
        keys = '0;
        repeat (2) @(posedge clk);
        #5;
    endtask

    task automatic enter_code(input int a, input int b, input int c);
        press(digit_key(a));
        press(digit_key(b));
        press(digit_key(c));
        press(KEY_ENTER);
    endtask

    initial begin
        int   d [4];
        int   i;
        int   toggles;
        int   waited;
        logic seen_zero;
        reset = 1'b1;
        keys  = '0;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        chk.start_test("digit_entry");
        for (i = 0; i < 4; i++) begin
            d[i] = random_digit();
            press(digit_key(d[i]));  // the fourth one is dropped
        end
        press(KEY_CLEAR);
        chk.finish_test();

        chk.start_test("correct_code");
        enter_code(2, 4, 6);
        toggles = chk.buzz_toggles;
        repeat (20) @(posedge clk);
        #5;
        // success tone flips every unit, a click only every second unit
        if (chk.buzz_toggles - toggles < 8)
            chk.report_problem("buzzer did not play the success tone after the lock opened");
        press(digit_key(random_digit()));
        press(KEY_CLEAR);
        chk.finish_test();

        chk.start_test("wrong_codes");
        enter_code(1, 3, 5);
        enter_code(9, 9, 9);
        enter_code(0, 0, 0);  // third miss starts the lockout
        press(digit_key(7));
        press(digit_key(8));
        waited    = 0;
        seen_zero = 1'b0;
        while (locked_out && waited < LOCKOUT_LIMIT) begin
            @(posedge clk);
            #5;
            if (display == 12'h000)
                seen_zero = 1'b1;
            waited++;
        end
        if (locked_out)
            chk.report_problem("locked_out stayed high after the lockout period");
        if (!seen_zero)
            chk.report_problem("countdown never showed 000 before the lockout ended");
        press(KEY_CLEAR);
        chk.finish_test();

        chk.start_test("change_code");
        press(KEY_SET);
        do begin
            for (i = 0; i < 3; i++)
                d[i] = random_digit();
        end while (d[0] == 2 && d[1] == 4 && d[2] == 6);
        enter_code(d[0], d[1], d[2]);  // stored as the new code
        enter_code(d[0], d[1], d[2]);
        press(KEY_CLEAR);
        enter_code(2, 4, 6);           // old code is now a miss
        press(KEY_CANCEL);
        chk.finish_test();

        chk.start_test("panic_cancel");
        enter_code(d[0], d[1], (d[2] + 1) % 10);
        press(digit_key(5));
        press(KEY_PANIC);
        press(digit_key(3));
        press(KEY_SET);
        press(KEY_CANCEL);
        chk.finish_test();

        $display("tests %0d, checks %0d, errors %0d",
                 chk.tests_run, chk.check_count, chk.error_count);
        if (chk.error_count == 0 && chk.check_count == 4 * NUM_PRESSES)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: tests/code_lock_checker.sv
`timescale 1ns/10ps

module code_lock_checker #(
    parameter int TICK_CYCLES = 20
) (
    input logic                     clk,
    input logic                     reset,
    input keypad_defs_pkg::keypad_t keys,
    input lock_defs_pkg::display_t  display,
    input lock_defs_pkg::count_t    entered,
    input lock_defs_pkg::tries_t    tries,
    input logic                     locked_out,
    input logic                     buzzer
);
    import keypad_defs_pkg::*;
    import lock_defs_pkg::*;

    typedef struct packed {
        logic [2:0] state;
        code_t      code;
        display_t   display;
        count_t     entered;
        tries_t     tries;
    } model_t;

    model_t  model;
    keypad_t prev_keys;
    int      cyc;
    int      lock_edge;       // edge that raised locked_out
    int      check_at;
    logic    check_pending;
    logic    was_locked;
    logic    buzzer_q;
    string   test_name    = "none";
    int      test_errors  = 0;
    int      tests_run    = 0;
    int      check_count  = 0;
    int      error_count  = 0;
    int      buzz_toggles = 0;

    function automatic int key_digit(keypad_t k);
        case (k)
            KEY_0:   return 0;
            KEY_1:   return 1;
            KEY_2:   return 2;
            KEY_3:   return 3;
            KEY_4:   return 4;
            KEY_5:   return 5;
            KEY_6:   return 6;
            KEY_7:   return 7;
            KEY_8:   return 8;
            KEY_9:   return 9;
            default: return -1;
        endcase
    endfunction

    function automatic logic known_key(keypad_t k);
        return key_digit(k) >= 0 || k == KEY_ENTER || k == KEY_SET || k == KEY_CLEAR
            || k == KEY_CANCEL || k == KEY_PANIC;
    endfunction

    // next lock state after one key press
    function automatic model_t apply_key(model_t m, keypad_t k);
        model_t     r;
        int         d;
        logic [3:0] nibble;
        r      = m;
        d      = key_digit(k);
        nibble = d[3:0];
        if (k == KEY_CANCEL) begin
            r.state   = ST_IDLE;
            r.display = 12'hFFF;
            r.entered = 2'd0;
            r.tries   = 2'd0;
        end else if (m.state == ST_IDLE || m.state == ST_SET_MODE) begin
            if (d >= 0) begin
                if (m.entered < 2'd3) begin
                    r.display = {m.display[7:0], nibble};
                    r.entered = m.entered + 2'd1;
                end
            end else if (k == KEY_ENTER && m.entered == 2'd3) begin
                r.display = 12'hFFF;
                r.entered = 2'd0;
                if (m.state == ST_SET_MODE) begin
                    r.code  = m.display;
                    r.state = ST_IDLE;
                end else if (m.display == m.code) begin
                    r.state   = ST_OPEN;
                    r.display = 12'hBCC;
                    r.entered = m.entered;  // count stays while open
                end else if (m.tries == 2'd2) begin
                    r.state = ST_LOCKOUT;   // third miss
                    r.tries = 2'd0;
                end else begin
                    r.tries = m.tries + 2'd1;
                end
            end else if (k == KEY_SET) begin
                r.state   = ST_SET_MODE;
                r.display = 12'hDDD;
                r.entered = 2'd0;
            end else if (k == KEY_CLEAR) begin
                r.display = 12'hFFF;
                r.entered = 2'd0;
            end else if (k == KEY_PANIC) begin
                r.state   = ST_ALARM;
                r.display = 12'h000;
                r.entered = 2'd0;
                r.tries   = 2'd0;
            end
        end else if (m.state == ST_OPEN && k == KEY_CLEAR) begin
            r.state   = ST_IDLE;
            r.display = 12'hFFF;
            r.entered = 2'd0;
        end
        return r;
    endfunction

    // lockout ends 21 seconds after the timer loads, plus one edge
    task automatic expire_if_due(input int n);
        if (model.state == ST_LOCKOUT && n >= lock_edge + 2 + 21 * TICK_CYCLES) begin
            model.state   = ST_IDLE;
            model.display = 12'hFFF;
        end
    endtask

    task automatic check_value(input string what, input logic [11:0] want,
                               input logic [11:0] got);
        check_count++;
        if (want !== got) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %s %s expected %0h actual %0h", test_name, what, want, got);
        end
    endtask

    task automatic compare_outputs(input int n);
        display_t want_display;
        int       elapsed;
        int       secs;
        expire_if_due(n);
        want_display = model.display;
        if (model.state == ST_LOCKOUT) begin
            elapsed = n - lock_edge - 2;
            if (elapsed < 0)
                elapsed = 0;
            secs         = 20 - elapsed / TICK_CYCLES;
            want_display = (secs / 10) * 16 + secs % 10;  // bcd seconds
        end
        check_value("display", want_display, display);
        check_value("entered", model.entered, entered);
        check_value("tries", model.tries, tries);
        check_value("locked_out", model.state == ST_LOCKOUT, locked_out);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, test_errors);
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        test_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            model.state   = ST_IDLE;
            model.code    = 12'h246;  // power-up combination
            model.display = 12'hFFF;
            model.entered = 2'd0;
            model.tries   = 2'd0;
            prev_keys     = '0;
            cyc           = 0;
            lock_edge     = 0;
            check_pending = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (check_pending && cyc == check_at) begin
                check_pending = 1'b0;
                compare_outputs(cyc - 1);  // values left by the previous edge
            end
            if (keys != prev_keys && known_key(keys)) begin
                expire_if_due(cyc);
                was_locked = (model.state == ST_LOCKOUT);
                model      = apply_key(model, keys);
                if (!was_locked && model.state == ST_LOCKOUT)
                    lock_edge = cyc + 1;
                check_pending = 1'b1;
                check_at      = cyc + 2;
            end
            prev_keys = keys;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            buzzer_q = 1'b0;
        end else begin
            if (buzzer !== buzzer_q)
                buzz_toggles++;
            buzzer_q = buzzer;
        end
    end

endmodule

// File: rtl/code_lock_top.sv
`timescale 1ns/10ps

module code_lock_top #(
    parameter int TICK_CYCLES = 50_000_000,  // one second at 50 MHz
    parameter int TONE_UNIT   = 25_000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  keypad_defs_pkg::keypad_t keys,
    output lock_defs_pkg::display_t  display,
    output lock_defs_pkg::count_t    entered,
    output lock_defs_pkg::tries_t    tries,
    output logic                     locked_out,
    output logic                     buzzer
);
    import keypad_defs_pkg::*;
    import lock_defs_pkg::*;

    logic      digit_valid;
    digit_t    digit;
    cmd_t      cmd;
    bcd_time_t time_left;
    logic      lockout_done;
    logic      lockout_start;
    logic      lockout_abort;
    logic      beep_click;
    logic      beep_success;
    logic      beep_fail;

    key_decoder u_key_decoder (
        .clk         (clk),
        .reset       (reset),
        .keys        (keys),
        .digit_valid (digit_valid),
        .digit       (digit),
        .cmd         (cmd)
    );

    code_lock_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .digit_valid   (digit_valid),
        .digit         (digit),
        .cmd           (cmd),
        .time_left     (time_left),
        .lockout_done  (lockout_done),
        .display       (display),
        .entered       (entered),
        .tries         (tries),
        .locked_out    (locked_out),
        .lockout_start (lockout_start),
        .lockout_abort (lockout_abort),
        .beep_click    (beep_click),
        .beep_success  (beep_success),
        .beep_fail     (beep_fail)
    );

    lockout_timer #(
        .TICK_CYCLES (TICK_CYCLES)
    ) u_timer (
        .clk       (clk),
        .reset     (reset),
        .start     (lockout_start),
        .abort     (lockout_abort),
        .time_left (time_left),
        .done      (lockout_done)
    );

    buzzer_pattern #(
        .TONE_UNIT (TONE_UNIT)
    ) u_buzzer (
        .clk     (clk),
        .reset   (reset),
        .click   (beep_click),
        .success (beep_success),
        .fail    (beep_fail),
        .buzzer  (buzzer)
    );

endmodule

// File: rtl/buzzer_pattern.sv
`timescale 1ns/10ps

module buzzer_pattern #(
    parameter int TONE_UNIT = 25_000
) (
    input  logic clk,
    input  logic reset,
    input  logic click,
    input  logic success,
    input  logic fail,
    output logic buzzer
);
    typedef enum logic [1:0] {
        PAT_IDLE,
        PAT_CLICK,
        PAT_SUCCESS,
        PAT_FAIL
    } pattern_t;

    localparam int UNIT_W = (TONE_UNIT > 1) ? $clog2(TONE_UNIT) : 1;

    // half periods and lengths, in tone units
    localparam logic [2:0]  CLICK_HALF   = 3'd2;
    localparam logic [2:0]  SUCCESS_HALF = 3'd1;
    localparam logic [2:0]  FAIL_HALF    = 3'd4;
    localparam logic [10:0] CLICK_LEN    = 11'd400;
    localparam logic [10:0] SUCCESS_LEN  = 11'd1200;
    localparam logic [10:0] FAIL_LEN     = 11'd600;
    localparam logic [10:0] GAP_START    = 11'd200;  // fail pattern pauses here
    localparam logic [10:0] GAP_END      = 11'd400;

    pattern_t          pattern;
    logic [UNIT_W-1:0] unit_cnt;
    logic              unit_tick;
    logic [2:0]        half_cnt;
    logic [10:0]       dur_cnt;
    logic              tone;
    logic [2:0]        half_len;
    logic [10:0]       dur_len;
    logic              in_gap;

    always_comb begin
        case (pattern)
            PAT_CLICK: begin
                half_len = CLICK_HALF;
                dur_len  = CLICK_LEN;
            end
            PAT_SUCCESS: begin
                half_len = SUCCESS_HALF;
                dur_len  = SUCCESS_LEN;
            end
            PAT_FAIL: begin
                half_len = FAIL_HALF;
                dur_len  = FAIL_LEN;
            end
            default: begin
                half_len = 3'd1;
                dur_len  = 11'd1;
            end
        endcase
    end

    assign unit_tick = (pattern != PAT_IDLE) && (unit_cnt == UNIT_W'(TONE_UNIT - 1));
    assign in_gap    = (pattern == PAT_FAIL) && (dur_cnt >= GAP_START) && (dur_cnt < GAP_END);
    assign buzzer    = tone && !in_gap;

    always_ff @(posedge clk) begin
        if (reset) begin
            pattern  <= PAT_IDLE;
            unit_cnt <= '0;
            half_cnt <= '0;
            dur_cnt  <= '0;
            tone     <= 1'b0;
        end else if (fail || success || click) begin  // latest request restarts
            pattern  <= fail ? PAT_FAIL : (success ? PAT_SUCCESS : PAT_CLICK);
            unit_cnt <= '0;
            half_cnt <= '0;
            dur_cnt  <= '0;
            tone     <= 1'b1;
        end else if (pattern != PAT_IDLE) begin
            if (unit_tick) begin
                unit_cnt <= '0;
                if (dur_cnt == dur_len - 11'd1) begin
                    pattern <= PAT_IDLE;
                    tone    <= 1'b0;
                end else begin
                    dur_cnt <= dur_cnt + 11'd1;
                    if (half_cnt == half_len - 3'd1) begin
                        half_cnt <= '0;
                        tone     <= ~tone;
                    end else begin
                        half_cnt <= half_cnt + 3'd1;
                    end
                end
            end else begin
                unit_cnt <= unit_cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/lockout_timer.sv
`timescale 1ns/10ps

module lockout_timer #(
    parameter int TICK_CYCLES = 50_000_000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     abort,
    output lock_defs_pkg::bcd_time_t time_left,
    output logic                     done
);
    import lock_defs_pkg::*;

    localparam int DIV_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [DIV_W-1:0] div_cnt;  // cycles within the current second
    logic             running;
    logic             tick;

    assign tick = running && (div_cnt == DIV_W'(TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            running   <= 1'b0;
            time_left <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running   <= 1'b1;
                div_cnt   <= '0;
                time_left <= LOCKOUT_SECONDS;
            end else if (abort) begin
                running   <= 1'b0;
                div_cnt   <= '0;
                time_left <= '0;
            end else if (running) begin
                if (tick) begin
                    div_cnt <= '0;
                    if (time_left == 8'h00) begin  // one extra second shown as 00
                        done    <= 1'b1;
                        running <= 1'b0;
                    end else if (time_left[3:0] == 4'd0) begin
                        time_left <= {time_left[7:4] - 4'd1, 4'd9};  // borrow from tens
                    end else begin
                        time_left[3:0] <= time_left[3:0] - 4'd1;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    a_bcd_digits: assert property (@(posedge clk) disable iff (reset)
        time_left[7:4] <= 4'd9 && time_left[3:0] <= 4'd9);

endmodule

// File: rtl/code_lock_ctrl.sv
`timescale 1ns/10ps

module code_lock_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     digit_valid,
    input  keypad_defs_pkg::digit_t  digit,
    input  keypad_defs_pkg::cmd_t    cmd,
    input  lock_defs_pkg::bcd_time_t time_left,
    input  logic                     lockout_done,
    output lock_defs_pkg::display_t  display,
    output lock_defs_pkg::count_t    entered,
    output lock_defs_pkg::tries_t    tries,
    output logic                     locked_out,
    output logic                     lockout_start,
    output logic                     lockout_abort,
    output logic                     beep_click,
    output logic                     beep_success,
    output logic                     beep_fail
);
    import keypad_defs_pkg::*;
    import lock_defs_pkg::*;

    localparam count_t FULL_ENTRY = 2'd3;

    lock_state_t state;
    code_t       code;  // stored combination

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_IDLE;
            code          <= DEFAULT_CODE;
            display       <= DISP_BLANK;
            entered       <= '0;
            tries         <= '0;
            locked_out    <= 1'b0;
            lockout_start <= 1'b0;
            lockout_abort <= 1'b0;
            beep_click    <= 1'b0;
            beep_success  <= 1'b0;
            beep_fail     <= 1'b0;
        end else begin
            lockout_start <= 1'b0;
            lockout_abort <= 1'b0;
            beep_click    <= 1'b0;
            beep_success  <= 1'b0;
            beep_fail     <= 1'b0;

            if (cmd == CMD_CANCEL) begin  // accepted in every state
                lockout_abort <= (state == ST_LOCKOUT);
                state         <= ST_IDLE;
                display       <= DISP_BLANK;
                entered       <= '0;
                tries         <= '0;
                locked_out    <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE, ST_SET_MODE: begin
                        if (digit_valid) begin
                            if (entered != FULL_ENTRY) begin  // fourth digit dropped
                                display    <= {display[7:0], digit};
                                entered    <= entered + 2'd1;
                                beep_click <= 1'b1;
                            end
                        end else begin
                            case (cmd)
                                CMD_ENTER: begin
                                    if (entered == FULL_ENTRY) begin
                                        if (state == ST_SET_MODE) begin
                                            code         <= display;  // new combination
                                            state        <= ST_IDLE;
                                            display      <= DISP_BLANK;
                                            entered      <= '0;
                                            beep_success <= 1'b1;
                                        end else if (display == code) begin
                                            state        <= ST_OPEN;
                                            display      <= DISP_OPEN;
                                            beep_success <= 1'b1;
                                        end else begin
                                            display   <= DISP_BLANK;
                                            entered   <= '0;
                                            beep_fail <= 1'b1;
                                            if (tries == tries_t'(MAX_TRIES - 1)) begin
                                                tries         <= '0;
                                                state         <= ST_LOCKOUT;
                                                locked_out    <= 1'b1;
                                                lockout_start <= 1'b1;
                                                display       <= {4'h0, LOCKOUT_SECONDS};
                                            end else begin
                                                tries <= tries + 2'd1;
                                            end
                                        end
                                    end
                                end
                                CMD_SET: begin
                                    state   <= ST_SET_MODE;
                                    display <= DISP_SET;
                                    entered <= '0;
                                end
                                CMD_CLEAR: begin
                                    display <= DISP_BLANK;
                                    entered <= '0;
                                end
                                CMD_PANIC: begin
                                    state     <= ST_ALARM;
                                    display   <= DISP_ALARM;
                                    entered   <= '0;
                                    tries     <= '0;
                                    beep_fail <= 1'b1;
                                end
                                default: ;
                            endcase
                        end
                    end
                    ST_OPEN: begin
                        if (cmd == CMD_CLEAR) begin
                            state   <= ST_IDLE;
                            display <= DISP_BLANK;
                            entered <= '0;
                        end
                    end
                    ST_LOCKOUT: begin
                        if (lockout_done) begin
                            state      <= ST_IDLE;
                            display    <= DISP_BLANK;
                            locked_out <= 1'b0;
                        end else if (!lockout_start) begin  // timer loads one cycle late
                            display <= {4'h0, time_left};
                        end
                    end
                    default: ;  // alarm waits for cancel
                endcase
            end
        end
    end

    // a full entry must saturate, never wrap back to zero
    a_entry_saturates: assert property (@(posedge clk) disable iff (reset)
        digit_valid && entered == FULL_ENTRY && state != ST_LOCKOUT
        |=> entered == FULL_ENTRY);

    a_locked_out_state: assert property (@(posedge clk) disable iff (reset)
        locked_out == (state == ST_LOCKOUT));

endmodule

// File: rtl/key_decoder.sv
`timescale 1ns/10ps

module key_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  keypad_defs_pkg::keypad_t keys,
    output logic                     digit_valid,
    output keypad_defs_pkg::digit_t  digit,
    output keypad_defs_pkg::cmd_t    cmd
);
    import keypad_defs_pkg::*;

    keypad_t prev_keys;
    digit_t  key_digit;  // F when the word is not a digit key
    cmd_t    key_cmd;
    logic    is_digit;

    always_comb begin
        key_digit = 4'hF;
        key_cmd   = CMD_NONE;
        case (keys)
            KEY_0:      key_digit = 4'd0;
            KEY_1:      key_digit = 4'd1;
            KEY_2:      key_digit = 4'd2;
            KEY_3:      key_digit = 4'd3;
            KEY_4:      key_digit = 4'd4;
            KEY_5:      key_digit = 4'd5;
            KEY_6:      key_digit = 4'd6;
            KEY_7:      key_digit = 4'd7;
            KEY_8:      key_digit = 4'd8;
            KEY_9:      key_digit = 4'd9;
            KEY_ENTER:  key_cmd = CMD_ENTER;
            KEY_SET:    key_cmd = CMD_SET;
            KEY_CLEAR:  key_cmd = CMD_CLEAR;
            KEY_CANCEL: key_cmd = CMD_CANCEL;
            KEY_PANIC:  key_cmd = CMD_PANIC;
            default:    key_cmd = CMD_NONE;  // zero or several keys held
        endcase
        is_digit = (key_digit <= 4'd9);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_keys   <= '0;
            digit_valid <= 1'b0;
            cmd         <= CMD_NONE;
        end else begin
            prev_keys <= keys;
            if (keys != prev_keys) begin  // press edge only
                digit_valid <= is_digit;
                cmd         <= key_cmd;
            end else begin
                digit_valid <= 1'b0;
                cmd         <= CMD_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        digit <= key_digit;  // qualified by digit_valid
    end

    a_one_event: assert property (@(posedge clk) disable iff (reset)
        !(digit_valid && cmd != CMD_NONE));

endmodule

// File: rtl/lock_defs_pkg.sv
package lock_defs_pkg;

    typedef logic [11:0] display_t;   // three display nibbles
    typedef logic [11:0] code_t;      // three code digits
    typedef logic [1:0]  count_t;     // digits entered so far
    typedef logic [1:0]  tries_t;     // wrong attempts
    typedef logic [7:0]  bcd_time_t;  // countdown, two bcd digits

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SET_MODE,
        ST_OPEN,
        ST_LOCKOUT,
        ST_ALARM
    } lock_state_t;

    // display patterns
    localparam display_t DISP_BLANK = 12'hFFF;
    localparam display_t DISP_OPEN  = 12'hBCC;  // reads as "ass" on the digits
    localparam display_t DISP_SET   = 12'hDDD;
    localparam display_t DISP_ALARM = 12'h000;

    localparam code_t     DEFAULT_CODE    = 12'h246;  // power-up combination
    localparam tries_t    MAX_TRIES       = 2'd3;
    localparam bcd_time_t LOCKOUT_SECONDS = 8'h20;    // bcd

endpackage

// File: rtl/keypad_defs_pkg.sv
package keypad_defs_pkg;

    typedef logic [15:0] keypad_t;  // raw one-hot keypad word
    typedef logic [3:0]  digit_t;   // decimal digit or display nibble

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_ENTER,
        CMD_SET,
        CMD_CLEAR,
        CMD_CANCEL,
        CMD_PANIC
    } cmd_t;

    // command keys
    localparam keypad_t KEY_ENTER  = 16'h0001;
    localparam keypad_t KEY_SET    = 16'h0010;
    localparam keypad_t KEY_CANCEL = 16'h0100;
    localparam keypad_t KEY_CLEAR  = 16'h1000;
    localparam keypad_t KEY_PANIC  = 16'h4000;

    // digit keys, scattered over the matrix
    localparam keypad_t KEY_0 = 16'h0008;
    localparam keypad_t KEY_1 = 16'h0080;
    localparam keypad_t KEY_2 = 16'h0040;
    localparam keypad_t KEY_3 = 16'h0020;
    localparam keypad_t KEY_4 = 16'h0800;
    localparam keypad_t KEY_5 = 16'h0400;
    localparam keypad_t KEY_6 = 16'h0200;
    localparam keypad_t KEY_7 = 16'h8000;
    localparam keypad_t KEY_8 = 16'h0002;
    localparam keypad_t KEY_9 = 16'h2000;

endpackage
